// File: rv_operand.f
+incdir+include
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_operand_decode.sv
src/rv_regfile.sv
src/rv_operand_stage.sv
tb/tb_clock_gen.sv
tb/rv_operand_sva.sv
tb/tb_rv_operand.sv

// File: tb/rv_operand_golden.txt
// test instr vld frdy wen wsel wdata flags | rdy ovld imm rs1 rs2 rs1_en rs2_en
// flags: 1 imm, 2 enables, 4 rs1, 8 rs2, 10 random write data
1 FFF10093 1 1 0 00 00000000 03 1 1 FFFFFFFF 00000000 00000000 1 0
1 FE51AE23 1 1 0 00 00000000 03 1 1 FFFFFFFC 00000000 00000000 1 1
1 04208AE3 1 1 0 00 00000000 03 1 1 00000854 00000000 00000000 1 1
1 800012B7 1 1 0 00 00000000 03 1 1 80001000 00000000 00000000 0 0
1 D555A0EF 1 1 0 00 00000000 03 1 1 FFF5AD54 00000000 00000000 0 0
2 002081B3 1 1 0 00 00000000 02 1 1 00000000 00000000 00000000 1 1
2 300322F3 1 1 0 00 00000000 02 1 1 00000000 00000000 00000000 1 0
2 3003D2F3 1 1 0 00 00000000 02 1 1 00000000 00000000 00000000 0 0
2 0080A383 1 1 0 00 00000000 03 1 1 00000008 00000000 00000000 1 0
3 00000000 0 1 1 05 12345678 00 1 1 00000000 00000000 00000000 0 0
3 00000000 0 1 1 06 CAFEF00D 00 1 1 00000000 00000000 00000000 0 0
3 006280B3 1 1 1 00 00000000 1E 1 1 00000000 12345678 CAFEF00D 1 1
3 00500133 1 1 0 00 00000000 0E 1 1 00000000 00000000 12345678 1 1
4 005381B3 1 1 1 07 0BADBEEF 0E 1 1 00000000 0BADBEEF 12345678 1 1
4 00628233 1 1 1 06 55AA55AA 0E 1 1 00000000 12345678 55AA55AA 1 1
5 006380B3 1 1 0 00 00000000 0E 1 1 00000000 0BADBEEF 55AA55AA 1 1
5 FFF10093 1 0 0 00 00000000 0E 0 1 00000000 0BADBEEF 55AA55AA 1 1
5 FFF10093 1 0 1 06 600DF00D 0E 0 1 00000000 0BADBEEF 600DF00D 1 1
5 FFF10093 1 0 1 09 00000000 1E 0 1 00000000 0BADBEEF 600DF00D 1 1
6 00000000 0 1 0 00 00000000 00 1 0 00000000 00000000 00000000 0 0
6 0080A383 1 0 0 00 00000000 03 0 1 00000008 00000000 00000000 1 0
6 00000000 0 1 0 00 00000000 00 1 0 00000000 00000000 00000000 0 0

// File: tb/tb_rv_operand.sv
/* Operand stage testbench
   Replays golden vectors on falling edges and checks the held operands */

`include "rv_operand_consts.svh"

module tb_rv_operand;

  timeunit 1ns;
  timeprecision 100ps;

  // ==========================================================================
  // Golden vector layout, one 32-bit word per column
  // ==========================================================================

  localparam int n_cols     = 15;
  localparam int c_test     = 0;
  localparam int c_instr    = 1;
  localparam int c_vld      = 2;
  localparam int c_frdy     = 3;
  localparam int c_wen      = 4;
  localparam int c_wsel     = 5;
  localparam int c_wdata    = 6;
  localparam int c_flags    = 7;
  localparam int c_rdy      = 8;
  localparam int c_ovld     = 9;
  localparam int c_imm      = 10;
  localparam int c_rs1      = 11;
  localparam int c_rs2      = 12;
  localparam int c_rs1_en   = 13;
  localparam int c_rs2_en   = 14;
  localparam int n_lines    = `RV_GOLDEN_LINES;
  // Reset, idle lead-in and slack on top of the vectors
  localparam int max_cycles = `RV_GOLDEN_LINES + 20;

  logic                   clk;
  logic                   rstz;
  rv_isa_pkg::word_t      instr_data;
  logic                   instr_vld;
  logic                   instr_rdy;
  logic                   fetch_rdy;
  rv_pipe_pkg::regwr_t    regwr;
  rv_pipe_pkg::operands_t operands;
  logic                   operands_vld;

  logic [31:0] vec [0:n_lines*n_cols-1];
  logic [31:0] rng_state;
  int          errors;
  int          checks;
  int          test_errs;
  int          test_checks;
  int          tests_done;
  int          cycle_cnt;
  int          line_idx;

  tb_clock_gen u_clk (
    .clk  (clk),
    .rstz (rstz)
  );

  rv_operand_stage uut (
    .clk          (clk),
    .rstz         (rstz),
    .instr_data   (instr_data),
    .instr_vld    (instr_vld),
    .instr_rdy    (instr_rdy),
    .fetch_rdy    (fetch_rdy),
    .operands     (operands),
    .operands_vld (operands_vld),
    .regwr        (regwr)
  );

  bind rv_regfile rv_operand_sva u_sva (
    .clk          (clk),
    .rstz         (rstz),
    .instr_vld    (instr_vld),
    .instr_rdy    (instr_rdy),
    .fetch_rdy    (fetch_rdy),
    .operands_vld (operands_vld),
    .fields       (fields),
    .regwr        (regwr),
    .operands     (operands)
  );

  // ==========================================================================
  // Helpers
  // ==========================================================================

  function automatic logic [31:0] vec_field(input int line, input int col);
    return vec[line * n_cols + col];
  endfunction

  // 32-bit xorshift, 13/17/5
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic string test_name(input int t);
    case (t)
      1: return "immediates";
      2: return "read enables";
      3: return "write, read and x0";
      4: return "same-cycle bypass";
      5: return "back-pressure";
      6: return "drain";
      default: return "unknown";
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    checks++;
    test_checks++;
    if (act_v !== exp_v) begin
      $display("Fail at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
      errors++;
      test_errs++;
    end
  endtask

  task automatic drive_line(input int i);
    logic [31:0] flags;
    flags      = vec_field(i, c_flags);
    instr_data = vec_field(i, c_instr);
    instr_vld  = (vec_field(i, c_vld) != 0);
    fetch_rdy  = (vec_field(i, c_frdy) != 0);
    regwr.en   = (vec_field(i, c_wen) != 0);
    regwr.sel  = rv_isa_pkg::reg_idx_t'(vec_field(i, c_wsel));
    // Don't-care write data comes from the generator
    if (flags[4]) begin
      rng_state  = xorshift32(rng_state);
      regwr.data = rng_state;
    end else begin
      regwr.data = vec_field(i, c_wdata);
    end
  endtask

  task automatic check_line(input int i);
    logic [31:0] flags;
    flags = vec_field(i, c_flags);
    check_val("instr_rdy", vec_field(i, c_rdy), instr_rdy);
    check_val("operands_vld", vec_field(i, c_ovld), operands_vld);
    if (flags[0]) check_val("operands.imm", vec_field(i, c_imm), operands.imm);
    if (flags[1]) begin
      check_val("operands.rs1_en", vec_field(i, c_rs1_en), operands.rs1_en);
      check_val("operands.rs2_en", vec_field(i, c_rs2_en), operands.rs2_en);
    end
    if (flags[2]) check_val("operands.rs1", vec_field(i, c_rs1), operands.rs1);
    if (flags[3]) check_val("operands.rs2", vec_field(i, c_rs2), operands.rs2);
  endtask

  task automatic report_test(input int t);
    $display("Test %0d %s: %0d checks, %0d errors", t, test_name(t), test_checks, test_errs);
    tests_done++;
    test_checks = 0;
    test_errs   = 0;
  endtask

  // ==========================================================================
  // Stimulus and checking
  // ==========================================================================

  initial begin
    instr_data  = '0;
    instr_vld   = 1'b0;
    fetch_rdy   = 1'b0;
    regwr       = '0;
    errors      = 0;
    checks      = 0;
    test_errs   = 0;
    test_checks = 0;
    tests_done  = 0;
    rng_state   = 32'd16;
    $readmemh("tb/rv_operand_golden.txt", vec);
    if (vec[0] === 'x) begin
      $display("Golden vector file could not be read");
      errors++;
    end
    @(negedge rstz);
    @(posedge rstz);
    // Just out of reset: nothing held, ready for fetch
    check_val("operands_vld", 32'd0, operands_vld);
    check_val("instr_rdy", 32'd1, instr_rdy);
    test_checks = 0;
    test_errs   = 0;
    @(negedge clk);
    for (line_idx = 0; line_idx < n_lines; line_idx++) begin
      drive_line(line_idx);
      @(negedge clk);
      // Result of the rising edge in between
      check_line(line_idx);
      if (line_idx == n_lines - 1 ||
          vec_field(line_idx + 1, c_test) != vec_field(line_idx, c_test)) begin
        report_test(vec_field(line_idx, c_test));
      end
    end
    $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
             tests_done, checks, errors, uut.u_regfile.u_sva.fail_cnt);
    if (errors == 0 && uut.u_regfile.u_sva.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", max_cycles);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// File: tb/rv_operand_sva.sv
/* Register file assertions
   Valid during reset, hold under back-pressure, x0 reads */

module rv_operand_sva (
  input logic                       clk,
  input logic                       rstz,
  input logic                       instr_vld,
  input logic                       instr_rdy,
  input logic                       fetch_rdy,
  input logic                       operands_vld,
  input rv_pipe_pkg::instr_fields_t fields,
  input rv_pipe_pkg::regwr_t        regwr,
  input rv_pipe_pkg::operands_t     operands
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, read by the testbench top
  int fail_cnt = 0;

  // Nothing held while reset is low
  a_reset_vld: assert property (@(posedge clk) !rstz |-> !operands_vld)
    else begin
      $error("operands_vld high while reset is asserted");
      fail_cnt++;
    end

  // Stalled without write-back, held bundle frozen
  a_hold: assert property (@(posedge clk) disable iff (!rstz)
    operands_vld && !fetch_rdy && !regwr.en |=> $stable(operands))
    else begin
      $error("held operands changed under back-pressure");
      fail_cnt++;
    end

  // x0 source captured as zero
  a_x0: assert property (@(posedge clk) disable iff (!rstz)
    instr_vld && instr_rdy && (fields.rs1 == '0) |=> (operands.rs1 == '0))
    else begin
      $error("rs1 value not zero after an x0 read");
      fail_cnt++;
    end

endmodule

// File: tb/tb_clock_gen.sv
/* Testbench clock and reset
   8 ns clock, active-low reset held for five cycles */

module tb_clock_gen #(
  parameter int period_ns = 8
) (
  output logic clk,
  output logic rstz
);

  timeunit 1ns;
  timeprecision 100ps;

  // Reset drops just after time zero so the async clear sees a real edge
  initial begin
    clk  = 1'b0;
    rstz = 1'b1;
    #1 rstz = 1'b0;
    repeat (5) @(posedge clk);
    // Release away from the rising edge
    @(negedge clk);
    rstz = 1'b1;
  end

  always #(period_ns / 2) clk = ~clk;

endmodule

// File: src/rv_operand_stage.sv
/* Operand stage top
   Decoder feeding the register file */

module rv_operand_stage (
  input  logic                   clk,
  input  logic                   rstz,
  // Fetch side
  input  rv_isa_pkg::word_t      instr_data,
  input  logic                   instr_vld,
  output logic                   instr_rdy,
  // Decode side
  input  logic                   fetch_rdy,
  output rv_pipe_pkg::operands_t operands,
  output logic                   operands_vld,
  // Write-back
  input  rv_pipe_pkg::regwr_t    regwr
);

  // Decoded fields, combinational from instr_data
  rv_pipe_pkg::instr_fields_t fields;

  rv_operand_decode u_decode (
    .instr  (instr_data),
    .fields (fields)
  );

  rv_regfile u_regfile (
    .clk          (clk),
    .rstz         (rstz),
    .fields       (fields),
    .instr_vld    (instr_vld),
    .fetch_rdy    (fetch_rdy),
    .regwr        (regwr),
    .instr_rdy    (instr_rdy),
    .operands     (operands),
    .operands_vld (operands_vld)
  );

endmodule

// File: src/rv_regfile.sv
/* Integer register file with operand capture
   Same-cycle bypass, x0 zeroing and refresh of held operands */

`include "rv_operand_consts.svh"

module rv_regfile (
  input  logic                       clk,
  input  logic                       rstz,
  input  rv_pipe_pkg::instr_fields_t fields,
  input  logic                       instr_vld,
  input  logic                       fetch_rdy,
  input  rv_pipe_pkg::regwr_t        regwr,
  output logic                       instr_rdy,
  output rv_pipe_pkg::operands_t     operands,
  output logic                       operands_vld
);

  // Integer registers including an x0 entry that is never read
  rv_isa_pkg::word_t regs [`RV_NREGS];

  // Indices of the held operands for write-back refresh
  rv_isa_pkg::reg_idx_t hold_rs1;
  rv_isa_pkg::reg_idx_t hold_rs2;

  rv_isa_pkg::word_t rd1;
  rv_isa_pkg::word_t rd2;
  logic              xfer;

  // Read port priority is x0, then bypass, then array
  function automatic rv_isa_pkg::word_t read_port(input rv_isa_pkg::reg_idx_t idx,
                                                  input rv_pipe_pkg::regwr_t  wr,
                                                  input rv_isa_pkg::word_t    stored);
    if (idx == '0) return '0;
    if (wr.en && (wr.sel == idx)) return wr.data;
    return stored;
  endfunction

  // ==========================================================================
  // Handshake
  // ==========================================================================

  // Take a new instruction when empty or when decode drains this one
  assign instr_rdy = ~operands_vld | fetch_rdy;
  assign xfer      = instr_vld & instr_rdy;

  assign rd1 = read_port(fields.rs1, regwr, regs[fields.rs1]);
  assign rd2 = read_port(fields.rs2, regwr, regs[fields.rs2]);

  // Valid set on transfer and cleared on a drain without write-back
  always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
      operands_vld <= 1'b0;
    end else if (xfer) begin
      operands_vld <= 1'b1;
    end else if (operands_vld && fetch_rdy && !regwr.en) begin
      operands_vld <= 1'b0;
    end
  end

  // ==========================================================================
  // Operand capture and refresh
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (xfer) begin
      operands.imm    <= fields.imm;
      operands.rs1    <= rd1;
      operands.rs2    <= rd2;
      operands.rs1_en <= fields.rs1_en;
      operands.rs2_en <= fields.rs2_en;
      hold_rs1        <= fields.rs1;
      hold_rs2        <= fields.rs2;
    end else if (operands_vld && regwr.en) begin
      // Stalled operands pick up the write-back while x0 stays zero
      if (hold_rs1 != '0 && hold_rs1 == regwr.sel) operands.rs1 <= regwr.data;
      if (hold_rs2 != '0 && hold_rs2 == regwr.sel) operands.rs2 <= regwr.data;
    end
  end

  // ==========================================================================
  // Array write
  // ==========================================================================

  always_ff @(posedge clk) begin
    if (regwr.en) begin
      regs[regwr.sel] <= regwr.data;
    end
  end

endmodule

// File: src/rv_operand_decode.sv
/* Operand decoder
   Immediate assembly for I/S/B/U/J formats and source read enables */

module rv_operand_decode (
  input  rv_isa_pkg::word_t          instr,
  output rv_pipe_pkg::instr_fields_t fields
);

  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_t funct3;
  logic                sign;

  // Format flags
  logic fmt_i;
  logic fmt_s;
  logic fmt_b;
  logic fmt_u;
  logic fmt_j;

  // Immediate segments, low to high
  // a [0], b [4:1], c [10:5], d [11], e [19:12], f [31:20]
  logic       imm_a;
  logic [3:0] imm_b;
  logic [5:0] imm_c;
  logic       imm_d;
  logic [7:0] imm_e;
  logic [11:0] imm_f;

  logic csr_rd;

  // ==========================================================================
  // Field slicing
  // ==========================================================================

  assign opcode = rv_isa_pkg::opcode_e'(instr[6:2]);
  assign funct3 = instr[14:12];
  // All formats sign-extend from bit 31
  assign sign   = instr[31];

  assign fmt_i = (opcode == rv_isa_pkg::OPIMM) || (opcode == rv_isa_pkg::JALR)
              || (opcode == rv_isa_pkg::LOAD);
  assign fmt_s = (opcode == rv_isa_pkg::STORE);
  assign fmt_b = (opcode == rv_isa_pkg::BR);
  assign fmt_u = (opcode == rv_isa_pkg::LUI) || (opcode == rv_isa_pkg::AUIPC);
  assign fmt_j = (opcode == rv_isa_pkg::JAL);

  // ==========================================================================
  // Immediate
  // ==========================================================================

  always_comb begin
    // Bit 0, zero for B/J/U
    if (fmt_i) imm_a = instr[20];
    else if (fmt_s) imm_a = instr[7];
    else imm_a = 1'b0;

    // Bits 4:1, S and B share rd position
    if (fmt_u) imm_b = 4'b0;
    else if (fmt_i || fmt_j) imm_b = instr[24:21];
    else imm_b = instr[11:8];

    // Bits 10:5, same place for all but U
    imm_c = fmt_u ? 6'b0 : instr[30:25];

    // Bit 11 moves around the most
    if (fmt_u) imm_d = 1'b0;
    else if (fmt_b) imm_d = instr[7];
    else if (fmt_j) imm_d = instr[20];
    else imm_d = sign;

    // Bits 19:12 come from the word for U and J
    imm_e = (fmt_u || fmt_j) ? instr[19:12] : {8{sign}};

    // Upper 12 bits
    imm_f = fmt_u ? instr[31:20] : {12{sign}};
  end

  // ==========================================================================
  // Read enables
  // ==========================================================================

  // CSRRW/CSRRS/CSRRC read rs1, the immediate forms do not
  assign csr_rd = (opcode == rv_isa_pkg::SYS)
               && (funct3 == rv_isa_pkg::f3_csrrw || funct3 == rv_isa_pkg::f3_csrrs
                || funct3 == rv_isa_pkg::f3_csrrc);

  always_comb begin
    fields.rs1 = instr[19:15];
    fields.rs2 = instr[24:20];
    fields.imm = {imm_f, imm_e, imm_d, imm_c, imm_b, imm_a};
    fields.rs1_en = (opcode == rv_isa_pkg::OPIMM) || (opcode == rv_isa_pkg::OP)
                 || (opcode == rv_isa_pkg::JALR) || (opcode == rv_isa_pkg::BR)
                 || (opcode == rv_isa_pkg::LOAD) || (opcode == rv_isa_pkg::STORE)
                 || csr_rd;
    // Only register-register, branch and store read rs2
    fields.rs2_en = (opcode == rv_isa_pkg::OP) || (opcode == rv_isa_pkg::BR)
                 || (opcode == rv_isa_pkg::STORE);
  end

endmodule

// File: src/rv_pipe_pkg.sv
/* Pipeline bundles of the operand stage
   Decoded fields, operand outputs and write-back port */

package rv_pipe_pkg;

  // ==========================================================================
  // Decoder to register file
  // ==========================================================================

  typedef struct packed {
    // Source register indices
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rs2;
    // Sign-extended immediate, already assembled
    rv_isa_pkg::word_t    imm;
    // Source register actually read by this opcode
    logic                 rs1_en;
    logic                 rs2_en;
  } instr_fields_t;

  // ==========================================================================
  // Operand stage outputs and write-back
  // ==========================================================================

  // Held operands for the next stage
  typedef struct packed {
    rv_isa_pkg::word_t imm;
    rv_isa_pkg::word_t rs1;
    rv_isa_pkg::word_t rs2;
    // Read enables, kept for hazard tracking downstream
    logic              rs1_en;
    logic              rs2_en;
  } operands_t;

  // Write-back strobe, index and data
  typedef struct packed {
    logic                 en;
    rv_isa_pkg::reg_idx_t sel;
    rv_isa_pkg::word_t    data;
  } regwr_t;

endpackage

// File: src/rv_isa_pkg.sv
/* RV32I instruction set types
   Major opcodes, register index, data word and funct3 codes */

`include "rv_operand_consts.svh"

package rv_isa_pkg;

  // ==========================================================================
  // Basic vectors
  // ==========================================================================

  // One integer data word
  typedef logic [`RV_XLEN-1:0] word_t;

  // Register index, x0 to x31
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_idx_t;

  // Minor function field
  typedef logic [2:0] funct3_t;

  // Major opcode, instruction bits 6 to 2
  // Bits 1:0 are always 2'b11 for 32-bit encodings
  typedef enum logic [4:0] {
    LOAD  = 5'b00000,
    OPIMM = 5'b00100,
    AUIPC = 5'b00101,
    STORE = 5'b01000,
    OP    = 5'b01100,
    LUI   = 5'b01101,
    BR    = 5'b11000,
    JALR  = 5'b11001,
    JAL   = 5'b11011,
    SYS   = 5'b11100
  } opcode_e;

  // SYSTEM funct3 codes for CSR forms with a register source
  localparam funct3_t f3_csrrw = 3'b001;
  localparam funct3_t f3_csrrs = 3'b010;
  localparam funct3_t f3_csrrc = 3'b011;

endpackage

// File: include/rv_operand_consts.svh
/* Operand stage constants
   Word width, register count and golden vector count */

`ifndef RV_OPERAND_CONSTS_SVH
`define RV_OPERAND_CONSTS_SVH

// Integer data word width
`define RV_XLEN 32

// Integer registers, x0 included
`define RV_NREGS 32

// Stimulus lines in the golden vector file
`define RV_GOLDEN_LINES 22

`endif
